//--- common/irqc_pkg.sv
/*
 * Interrupt controller types
 * Wishbone request and response, channel control, mask and vector
 */
`default_nettype none

`include "irqc_settings.svh"

package irqc_pkg;

   // Index of one interrupt line
   typedef logic [$clog2(`IRQC_NIRQ)-1:0] irq_idx_t;

   // Master side of the Wishbone classic port
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [`IRQC_AW-1:0]  adr;
      logic [`IRQC_DW-1:0]  dat;
   } wb_req_t;

   // Slave side, single-cycle ack
   typedef struct packed {
      logic                 ack;
      logic [`IRQC_DW-1:0]  dat;
   } wb_rsp_t;

   // Per-channel controls
   typedef struct packed {
      logic edge_mode;  // 1 selects rising-edge latch
      logic clr;        // One-cycle clear of the edge latch
   } chan_ctrl_t;

   // Mask bits plus global enable
   typedef struct packed {
      logic [`IRQC_NIRQ-1:0] imr;  // 1 blocks the line
      logic                  ire;
   } irq_mask_t;

   // Winning line from the arbiter
   typedef struct packed {
      logic     valid;
      irq_idx_t idx;
   } irq_vec_t;

endpackage

`default_nettype wire

//--- common/irqc_settings.svh
/*
 * Interrupt controller sizing and register map
 * Line count, bus widths and word offsets
 */
`ifndef IRQC_SETTINGS_SVH
`define IRQC_SETTINGS_SVH

// Interrupt lines, never more than the data width
`define IRQC_NIRQ 8
`define IRQC_DW 32
// Word address bits on the Wishbone port
`define IRQC_AW 3

// Word offsets
`define IRQC_REG_IMR 3'd0
`define IRQC_REG_IRR 3'd1
`define IRQC_REG_CTRL 3'd2
`define IRQC_REG_EDGE 3'd3
`define IRQC_REG_CLR 3'd4
`define IRQC_REG_VEC 3'd5

`endif

//--- irqc/irq_arbiter.sv
/*
 * Fixed-priority arbiter
 * Masking, lowest-index select, registered intr and vector
 */
`timescale 1ns/1ps
`default_nettype none

`include "irqc_settings.svh"

module irq_arbiter (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`IRQC_NIRQ-1:0]   pending,
   input  irqc_pkg::irq_mask_t     mask,
   output logic                    intr,
   output irqc_pkg::irq_vec_t      vec
);
   import irqc_pkg::*;

   logic [`IRQC_NIRQ-1:0] masked;
   logic                  sel_valid;
   irq_idx_t              sel_idx;
   logic                  valid_r;
   irq_idx_t              idx_r;
   logic                  intr_r;

   // IMR bit set blocks the line
   assign masked = pending & ~mask.imr;

   // Scan downward so the lowest line is the last hit
   always_comb begin
      sel_valid = 1'b0;
      sel_idx   = '0;
      for (int i = `IRQC_NIRQ - 1; i >= 0; i--) begin
         if (masked[i]) begin
            sel_valid = 1'b1;
            sel_idx   = irq_idx_t'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_r <= 1'b0;
         idx_r   <= '0;
         intr_r  <= 1'b0;
      end else begin
         valid_r <= sel_valid;
         idx_r   <= sel_idx;
         // Only intr waits on IRE
         intr_r  <= sel_valid & mask.ire;
      end
   end

   // VEC shows valid even with IRE off, for polling
   assign vec  = irq_vec_t'{valid: valid_r, idx: idx_r};
   assign intr = intr_r;

endmodule

`default_nettype wire

//--- irqc/irq_channel.sv
/*
 * One interrupt line
 * Two-flop synchronizer, edge detect and sticky pending latch
 */
`timescale 1ns/1ps
`default_nettype none

module irq_channel (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 irq,
   input  irqc_pkg::chan_ctrl_t ctrl,
   output logic                 pending
);

   logic sync0_r;
   logic sync1_r;
   logic prev_r;
   logic latch_r;
   logic rise;

   // Raw line may change at any time
   always_ff @(posedge clk) begin
      if (rst) begin
         sync0_r <= 1'b0;
         sync1_r <= 1'b0;
         prev_r  <= 1'b0;
      end else begin
         sync0_r <= irq;
         sync1_r <= sync0_r;
         // Previous synchronized value
         prev_r  <= sync1_r;
      end
   end

   assign rise = sync1_r & ~prev_r;

   // Edge latch, set beats clear
   always_ff @(posedge clk) begin
      if (rst) begin
         latch_r <= 1'b0;
      end else if (ctrl.edge_mode && rise) begin
         latch_r <= 1'b1;
      end else if (ctrl.clr || !ctrl.edge_mode) begin
         // Level mode keeps it empty
         latch_r <= 1'b0;
      end
   end

   // Level mode follows the synchronized line
   assign pending = ctrl.edge_mode ? latch_r : sync1_r;

endmodule

`default_nettype wire

//--- irqc/irqc_regs.sv
/*
 * Wishbone classic register block
 * Holds IMR, IRE and EDGE, turns CLR writes into pulses, reads status
 */
`timescale 1ns/1ps
`default_nettype none

`include "irqc_settings.svh"

module irqc_regs (
   input  logic                                  clk,
   input  logic                                  rst,
   input  irqc_pkg::wb_req_t                     wb_req,
   output irqc_pkg::wb_rsp_t                     wb_rsp,
   output irqc_pkg::chan_ctrl_t [`IRQC_NIRQ-1:0] ctrl,
   output irqc_pkg::irq_mask_t                   mask,
   input  logic [`IRQC_NIRQ-1:0]                 pending,
   input  irqc_pkg::irq_vec_t                    vec
);
   import irqc_pkg::*;

   logic                  ack_r;
   logic [`IRQC_DW-1:0]   rdat_r;
   logic [`IRQC_DW-1:0]   rd_word;
   logic                  req_new;
   logic                  wr_en;

   // Control registers
   logic [`IRQC_NIRQ-1:0] imr_r;
   logic                  ire_r;
   logic [`IRQC_NIRQ-1:0] edge_r;
   logic [`IRQC_NIRQ-1:0] clr_r;

   // New cycle seen, ack not yet given
   assign req_new = wb_req.cyc & wb_req.stb & ~ack_r;
   assign wr_en   = req_new & wb_req.we;

   // Ack, register writes and clear pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_r  <= 1'b0;
         imr_r  <= '1;
         ire_r  <= 1'b0;
         edge_r <= '0;
         clr_r  <= '0;
      end else begin
         ack_r <= req_new;
         // Clear pulse lasts only the ack cycle
         clr_r <= '0;
         if (wr_en) begin
            case (wb_req.adr)
               `IRQC_REG_IMR:  imr_r  <= wb_req.dat[`IRQC_NIRQ-1:0];
               `IRQC_REG_CTRL: ire_r  <= wb_req.dat[0];
               `IRQC_REG_EDGE: edge_r <= wb_req.dat[`IRQC_NIRQ-1:0];
               `IRQC_REG_CLR:  clr_r  <= wb_req.dat[`IRQC_NIRQ-1:0];
               // IRR and VEC are read-only
               default: ;
            endcase
         end
      end
   end

   // Read mux, unused bits read as zero
   always_comb begin
      rd_word = '0;
      case (wb_req.adr)
         `IRQC_REG_IMR:  rd_word[`IRQC_NIRQ-1:0] = imr_r;
         `IRQC_REG_IRR:  rd_word[`IRQC_NIRQ-1:0] = pending;
         `IRQC_REG_CTRL: rd_word[0] = ire_r;
         `IRQC_REG_EDGE: rd_word[`IRQC_NIRQ-1:0] = edge_r;
         `IRQC_REG_VEC: begin
            // Valid in the top bit, index at the bottom
            rd_word[`IRQC_DW-1] = vec.valid;
            rd_word[$bits(irq_idx_t)-1:0] = vec.idx;
         end
         // CLR reads back zero
         default: ;
      endcase
   end

   // Read data captured with ack
   always_ff @(posedge clk) begin
      if (req_new) begin
         rdat_r <= rd_word;
      end
   end

   assign wb_rsp = wb_rsp_t'{ack: ack_r, dat: rdat_r};

   assign mask = irq_mask_t'{imr: imr_r, ire: ire_r};

   // Fan out to channels
   always_comb begin
      for (int i = 0; i < `IRQC_NIRQ; i++) begin
         ctrl[i].edge_mode = edge_r[i];
         ctrl[i].clr       = clr_r[i];
      end
   end

endmodule

`default_nettype wire

//--- irqc_top.f
+incdir+common
common/irqc_pkg.sv
irqc/irqc_regs.sv
irqc/irq_channel.sv
irqc/irq_arbiter.sv
logic/irqc_top.sv
tests/irqc_clkgen.sv
tests/irqc_sva.sv
tests/irqc_tb.sv

//--- logic/irqc_top.sv
/*
 * Interrupt controller top level
 * Register block, channel array and arbiter
 */
`timescale 1ns/1ps
`default_nettype none

`include "irqc_settings.svh"

module irqc_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`IRQC_NIRQ-1:0] irqs,
   input  irqc_pkg::wb_req_t     wb_req,
   output irqc_pkg::wb_rsp_t     wb_rsp,
   output logic                  intr
);
   import irqc_pkg::*;

   // Per-line controls from the register block
   chan_ctrl_t [`IRQC_NIRQ-1:0] ctrl;
   irq_mask_t                   mask;
   irq_vec_t                    vec;
   // One bit per channel
   logic [`IRQC_NIRQ-1:0]       pending;

   irqc_regs irqc_regs_inst (
      .clk     (clk),
      .rst     (rst),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .ctrl    (ctrl),
      .mask    (mask),
      .pending (pending),
      .vec     (vec)
   );

   // Identical channels, one per line
   for (genvar i = 0; i < `IRQC_NIRQ; i++) begin : g_chan
      irq_channel irq_channel_inst (
         .clk     (clk),
         .rst     (rst),
         .irq     (irqs[i]),
         .ctrl    (ctrl[i]),
         .pending (pending[i])
      );
   end

   irq_arbiter irq_arbiter_inst (
      .clk     (clk),
      .rst     (rst),
      .pending (pending),
      .mask    (mask),
      .intr    (intr),
      .vec     (vec)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the interrupt controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f irqc_top.f \
   --top-module irqc_tb \
   --Mdir obj_dir \
   -o irqc_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build exited with status $status"
   exit 1
fi

out=$(./obj_dir/irqc_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1

//--- tests/irqc_clkgen.sv
/*
 * Testbench clock and reset source
 * 40 ns clock, reset held for the first 4 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module irqc_clkgen (
   output logic clk,
   output logic rst
);
   localparam int PERIOD_NS  = 40;
   localparam int RST_CYCLES = 4;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release lands just after an edge, like the other inputs
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #2 rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- tests/irqc_sva.sv
/*
 * Concurrent checks on the interrupt controller top level
 * Ack pulse width, ack framing, intr gated by IRE
 */
`timescale 1ns/1ps
`default_nettype none

module irqc_sva (
   input logic                clk,
   input logic                rst,
   input irqc_pkg::wb_req_t   wb_req,
   input irqc_pkg::wb_rsp_t   wb_rsp,
   input irqc_pkg::irq_mask_t mask,
   input logic                intr
);

   // Ack is one cycle wide
   ack_single: assert property (
      @(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
      else $error("ack held for more than one cycle");

   // No ack outside an open bus cycle
   ack_framed: assert property (
      @(posedge clk) disable iff (rst) wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
      else $error("ack without cyc and stb");

   // Registered intr needs IRE on the edge before
   intr_gated: assert property (
      @(posedge clk) disable iff (rst) intr |-> $past(mask.ire))
      else $error("intr raised while IRE was clear");

endmodule

`default_nettype wire

//--- tests/irqc_tb.sv
/*
 * Interrupt controller testbench
 * Wishbone tasks, stimulus table, random level rows, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "irqc_settings.svh"

module irqc_tb;
   import irqc_pkg::*;

   localparam int N      = `IRQC_NIRQ;
   localparam int CLK_NS = 40;
   localparam int NROWS  = 14;
   localparam int NRAND  = 20;
   localparam int WD_NS  = (NROWS + NRAND) * 40 * CLK_NS;
   localparam logic [31:0] ALL_LINES = (32'd1 << N) - 32'd1;
   localparam logic [31:0] VALID     = 32'h8000_0000;

   // One table row with its expected results
   typedef struct packed {
      logic [N-1:0] imr;
      logic         ire;
      logic [N-1:0] edge_m;
      logic [N-1:0] pat_a;
      logic         two;     // Pattern A becomes a 3-cycle pulse
      logic [N-1:0] pat_b;
      logic         do_clr;
      logic [N-1:0] clr;
      logic         exp_intr;
      logic [31:0]  exp_vec;
      logic [N-1:0] exp_irr;
   } row_t;

   logic         clk;
   logic         rst;
   logic [N-1:0] irqs;
   wb_req_t      wb_req;
   wb_rsp_t      wb_rsp;
   logic         intr;
   row_t         rows [NROWS];
   int           errors;
   int           tests_run;
   int           tests_bad;
   logic [31:0]  rnd;

   irqc_clkgen irqc_clkgen_inst (.clk(clk), .rst(rst));

   irqc_top irqc_top_inst (
      .clk    (clk),
      .rst    (rst),
      .irqs   (irqs),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .intr   (intr)
   );

   bind irqc_top irqc_sva irqc_sva_inst (
      .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp), .mask(mask), .intr(intr)
   );

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Classic cycle held until the master has seen ack
   // One idle cycle follows the drop of stb
   task automatic bus_access(input logic wr, input logic [`IRQC_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      int   waited;
      logic got_ack;
      waited  = 0;
      got_ack = 1'b0;
      rdat    = '0;
      wb_req  = wb_req_t'{cyc: 1'b1, stb: 1'b1, we: wr, adr: adr, dat: wdat};
      while (!got_ack && waited < 10) begin
         @(posedge clk);
         #2;
         waited++;
         if (wb_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = wb_rsp.dat;
         end
      end
      assert (got_ack) else begin
         $display("bus timeout: no ack within 10 cycles for address %0d at %0d ns", adr, $time);
         errors++;
      end
      @(posedge clk);
      #2;
      wb_req = '0;
      assert (!wb_rsp.ack) else begin
         $display("ack given twice for address %0d at %0d ns", adr, $time);
         errors++;
      end
      wait_cycles(1);
   endtask

   task automatic bus_write(input logic [`IRQC_AW-1:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      bus_access(1'b1, adr, wdat, unused);
   endtask

   task automatic bus_read(input logic [`IRQC_AW-1:0] adr, output logic [31:0] rdat);
      bus_access(1'b0, adr, 32'h0, rdat);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: %0d mismatches", name, errors - errs_before);
      end
   endtask

   // Level mode pending follows the input
   // Lowest unmasked line wins
   function automatic row_t predict_level(logic [N-1:0] imr, logic ire, logic [N-1:0] pat);
      row_t         r;
      logic [N-1:0] live;
      r       = '0;
      r.imr   = imr;
      r.ire   = ire;
      r.pat_a = pat;
      r.exp_irr = pat;
      live = pat & ~imr;
      for (int i = 0; i < N; i++) begin
         if (live[i] && !r.exp_vec[31]) r.exp_vec = VALID | 32'(i);
      end
      r.exp_intr = (|live) & ire;
      return r;
   endfunction

   task automatic apply_row(input string name, input row_t r);
      int          errs_before;
      logic [31:0] rd;
      errs_before = errors;
      irqs = '0;
      // Level mode for a moment empties every edge latch
      bus_write(`IRQC_REG_EDGE, 32'h0);
      bus_write(`IRQC_REG_IMR, 32'(r.imr));
      bus_write(`IRQC_REG_CTRL, 32'(r.ire));
      bus_write(`IRQC_REG_EDGE, 32'(r.edge_m));
      irqs = r.pat_a;
      if (r.two) begin
         wait_cycles(3);
         irqs = r.pat_b;
      end
      // Longer than the 4-cycle input to intr bound
      wait_cycles(6);
      if (r.do_clr) begin
         bus_write(`IRQC_REG_CLR, 32'(r.clr));
         wait_cycles(6);
      end
      check_val("intr", 32'(intr), 32'(r.exp_intr));
      bus_read(`IRQC_REG_VEC, rd);
      check_val("vec", rd, r.exp_vec);
      bus_read(`IRQC_REG_IRR, rd);
      check_val("irr", rd, 32'(r.exp_irr));
      report_test(name, errs_before);
   endtask

   task automatic check_reset_state();
      int          errs_before;
      logic [31:0] rd;
      errs_before = errors;
      bus_read(`IRQC_REG_IMR, rd);
      check_val("imr", rd, ALL_LINES);
      bus_read(`IRQC_REG_EDGE, rd);
      check_val("edge", rd, 32'h0);
      bus_read(`IRQC_REG_CTRL, rd);
      check_val("ctrl", rd, 32'h0);
      bus_read(`IRQC_REG_VEC, rd);
      check_val("vec", rd, 32'h0);
      // Every line pending but still masked
      irqs = '1;
      wait_cycles(6);
      check_val("intr", 32'(intr), 32'h0);
      bus_read(`IRQC_REG_IRR, rd);
      check_val("irr", rd, ALL_LINES);
      irqs = '0;
      report_test("reset", errs_before);
   endtask

   task automatic check_read_only();
      int          errs_before;
      logic [31:0] rd;
      errs_before = errors;
      irqs = N'(2);
      bus_write(`IRQC_REG_EDGE, 32'h0);
      bus_write(`IRQC_REG_IMR, 32'h0);
      bus_write(`IRQC_REG_CTRL, 32'h1);
      wait_cycles(6);
      // Bit 0 low so a stray CTRL write would drop IRE
      bus_write(`IRQC_REG_IRR, 32'hffff_fffe);
      bus_write(`IRQC_REG_VEC, 32'hffff_fffe);
      bus_read(`IRQC_REG_IRR, rd);
      check_val("irr", rd, 32'h2);
      bus_read(`IRQC_REG_VEC, rd);
      check_val("vec", rd, VALID | 32'h1);
      bus_read(`IRQC_REG_CTRL, rd);
      check_val("ctrl", rd, 32'h1);
      irqs = '0;
      report_test("read-only", errs_before);
   endtask

   // Columns imr ire edge pat_a two pat_b do_clr clr | intr vec irr
   task automatic fill_table();
      rows[0]  = '{8'hfe, 1'b1, 8'h00, 8'h01, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, VALID, 8'h01};
      rows[1]  = '{8'hff, 1'b1, 8'h00, 8'h01, 1'b0, 8'h00, 1'b0, 8'h00, 1'b0, 32'h0, 8'h01};
      rows[2]  = '{8'hfe, 1'b0, 8'h00, 8'h01, 1'b0, 8'h00, 1'b0, 8'h00, 1'b0, VALID, 8'h01};
      // Priority among lines 2, 3 and 5
      rows[3]  = '{8'h00, 1'b1, 8'h00, 8'h2c, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, VALID | 2, 8'h2c};
      rows[4]  = '{8'h04, 1'b1, 8'h00, 8'h2c, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, VALID | 3, 8'h2c};
      rows[5]  = '{8'h0c, 1'b1, 8'h00, 8'h2c, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, VALID | 5, 8'h2c};
      rows[6]  = '{8'h00, 1'b1, 8'h00, 8'h80, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, VALID | 7, 8'h80};
      // Edge pulse on line 4 that is then cleared
      rows[7]  = '{8'hef, 1'b1, 8'h10, 8'h10, 1'b1, 8'h00, 1'b0, 8'h00, 1'b1, VALID | 4, 8'h10};
      rows[8]  = '{8'hef, 1'b1, 8'h10, 8'h10, 1'b1, 8'h00, 1'b1, 8'h10, 1'b0, 32'h0, 8'h00};
      // Clear has no hold on a level line
      rows[9]  = '{8'hef, 1'b1, 8'h00, 8'h10, 1'b0, 8'h00, 1'b1, 8'h10, 1'b1, VALID | 4, 8'h10};
      // Input stays high so no second edge follows the clear
      rows[10] = '{8'hef, 1'b1, 8'h10, 8'h10, 1'b0, 8'h00, 1'b1, 8'h10, 1'b0, 32'h0, 8'h00};
      // Edge line 0 next to level line 3
      rows[11] = '{8'h00, 1'b1, 8'h01, 8'h09, 1'b1, 8'h08, 1'b0, 8'h00, 1'b1, VALID, 8'h09};
      rows[12] = '{8'h00, 1'b1, 8'h01, 8'h09, 1'b1, 8'h08, 1'b1, 8'h01, 1'b1, VALID | 3, 8'h08};
      rows[13] = '{8'h00, 1'b1, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00, 1'b0, 32'h0, 8'h00};
   endtask

   initial begin
      rnd       = $urandom(32'he0e6);
      irqs      = '0;
      wb_req    = '0;
      errors    = 0;
      tests_run = 0;
      tests_bad = 0;
      wait (rst == 1'b0);
      wait_cycles(1);
      check_reset_state();
      fill_table();
      for (int i = 0; i < NROWS; i++) begin
         apply_row($sformatf("row %0d", i), rows[i]);
      end
      // imr, pattern and ire from one draw
      for (int i = 0; i < NRAND; i++) begin
         rnd = $urandom();
         apply_row($sformatf("random %0d", i), predict_level(rnd[7:0], rnd[16], rnd[15:8]));
      end
      check_read_only();
      $display("summary: %0d tests, %0d with mismatches, %0d errors",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Budget of 40 cycles per row
   initial begin
      #(WD_NS);
      $display("watchdog: run did not finish within %0d ns", WD_NS);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
